// ==== files.f ====
+incdir+logic
logic/spi_pkg.sv
logic/cmd_dispatch.sv
logic/spi_master.sv
logic/read_collect.sv
logic/spi_hub_top.sv
testbench/spi_slave_model.sv
testbench/tb_spi_hub.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the SPI hub testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_spi_hub -f files.f > build.log 2>&1 \
  || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/Vtb_spi_hub > "$LOG" 2>&1
cat "$LOG"

grep -q "Simulation failed" "$LOG" \
  && { echo "FAIL"; exit 1; }

grep -q "Simulation completed successfully" "$LOG" \
  && { echo "PASS"; exit 0; } \
  || { echo "FAIL: no result line in $LOG"; exit 1; }

// ==== testbench/tb_spi_hub.sv ====
`include "spi_params.svh"

module tb_spi_hub;
  import spi_pkg::*;

  localparam int MAX_CYCLES = 40000; // About 250 transactions of 130 cycles plus margin
  localparam int WAIT_LIMIT = 1000;
  localparam int REGS       = 2**`SPI_ADDR_W;

  logic                   clk;
  logic                   rst_n;
  logic                   req_valid;
  logic                   req_ready;
  host_req_t              req;
  logic                   rsp_valid;
  logic                   rsp_ready;
  read_rsp_t              rsp;
  logic [`SPI_LANES-1:0]  sclk;
  logic [`SPI_LANES-1:0]  cs_n;
  logic [`SPI_LANES-1:0]  mosi;
  logic [`SPI_LANES-1:0]  miso;

  logic [`SPI_DATA_W-1:0] sb [`SPI_LANES][REGS]; // Expected peripheral contents
  read_rsp_t              pending [$];           // Reads issued and not yet answered
  int                     seed       = 22;
  int                     cycles     = 0;
  int                     checks     = 0;
  int                     value_errs = 0;
  int                     proto_errs = 0;

  initial clk = 1'b0;
  always #5 clk = ~clk;

  spi_hub_top u_spi_hub_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req       (req),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp       (rsp),
    .sclk      (sclk),
    .cs_n      (cs_n),
    .mosi      (mosi),
    .miso      (miso)
  );

  for (genvar i = 0; i < `SPI_LANES; i++)
  begin : g_slave
    spi_slave_model #(
      .LANE (i)
    ) u_slave (
      .clk   (clk),
      .rst_n (rst_n),
      .sclk  (sclk[i]),
      .cs_n  (cs_n[i]),
      .mosi  (mosi[i]),
      .miso  (miso[i])
    );
  end

  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES)
    begin
      $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("Simulation failed");
      $finish;
    end
  end

  // ====================
  // Checks
  // ====================

  task automatic check_rsp(input read_rsp_t got, input read_rsp_t exp);
    checks++;
    if (got !== exp)
    begin
      value_errs++;
      $display("ERR %0t: response lane %0d addr %0d data %02h, expected lane %0d addr %0d data %02h",
               $time, got.lane, got.addr, got.data, exp.lane, exp.addr, exp.data);
    end
  endtask

  task automatic check_idle(input logic [`SPI_LANES-1:0] cs_got,
                            input logic [`SPI_LANES-1:0] sclk_got);
    checks++;
    if ((cs_got !== '1) || (sclk_got !== '0))
    begin
      value_errs++;
      $display("ERR %0t: lanes not idle, cs_n %b sclk %b", $time, cs_got, sclk_got);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp)
    begin
      value_errs++;
      $display("ERR %0t: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  // ====================
  // Host side
  // ====================

  function automatic host_req_t make_req(input int lane, input spi_op_e op,
                                         input int addr, input int data);
    host_req_t r;
    r.lane     = `SPI_LANE_W'(lane);
    r.cmd.op   = op;
    r.cmd.addr = `SPI_ADDR_W'(addr);
    r.cmd.data = `SPI_DATA_W'(data);
    return r;
  endfunction

  function automatic logic pick_ready(input bit stall);
    return stall ? logic'(($random(seed) & 3) != 0) : 1'b1; // Stalls one cycle in four
  endfunction

  task automatic send_req(input host_req_t r);
    int        waited;
    read_rsp_t exp;
    waited    = 0;
    req_valid = 1'b1;
    req       = r;
    while (!req_ready && (waited < WAIT_LIMIT))
    begin
      @(negedge clk);
      waited++;
    end
    if (!req_ready)
    begin
      proto_errs++;
      $display("Request to lane %0d was not accepted within %0d cycles", r.lane, WAIT_LIMIT);
    end
    else if (r.cmd.op == OP_WRITE)
    begin
      sb[r.lane][r.cmd.addr] = r.cmd.data;
    end
    else
    begin
      exp.lane = r.lane;
      exp.addr = r.cmd.addr;
      exp.data = sb[r.lane][r.cmd.addr];
      pending.push_back(exp);
    end
    @(negedge clk); // Handshake completed on the rising edge in between
    req_valid = 1'b0;
  endtask

  task automatic get_rsp(input bit stall, output read_rsp_t got);
    int waited;
    int idx;
    waited    = 0;
    idx       = -1;
    got       = '0;
    rsp_ready = pick_ready(stall);
    while (!(rsp_valid && rsp_ready) && (waited < WAIT_LIMIT))
    begin
      @(negedge clk);
      waited++;
      rsp_ready = pick_ready(stall);
    end
    if (!(rsp_valid && rsp_ready))
    begin
      proto_errs++;
      $display("No read response arrived within %0d cycles", WAIT_LIMIT);
    end
    else
    begin
      got = rsp;
      for (int i = 0; i < pending.size(); i++)
      begin
        if ((idx < 0) && (pending[i].lane == got.lane))
        begin
          idx = i;
        end
      end
      if (idx < 0)
      begin
        proto_errs++;
        $display("Unexpected read response from lane %0d with no read pending", got.lane);
      end
      else
      begin
        check_rsp(got, pending[idx]);
        pending.delete(idx);
      end
    end
    @(negedge clk);
    rsp_ready = 1'b0;
  endtask

  // ====================
  // Tests
  // ====================

  task automatic test_reset_state;
    check_idle(cs_n, sclk);
    check_flag("rsp_valid", rsp_valid, 1'b0);
    check_flag("req_ready", req_ready, 1'b1);
  endtask

  task automatic test_reset_values;
    read_rsp_t got;
    for (int l = 0; l < `SPI_LANES; l++)
    begin
      for (int a = 0; a < REGS; a++)
      begin
        send_req(make_req(l, OP_READ, a, 0));
        get_rsp(1'b0, got);
      end
    end
  endtask

  task automatic test_write_read;
    read_rsp_t got;
    send_req(make_req(2, OP_WRITE, 5, 'ha5));
    send_req(make_req(2, OP_READ, 5, 0));
    get_rsp(1'b0, got);
    send_req(make_req(2, OP_READ, 4, 0)); // Neighbouring address untouched
    get_rsp(1'b0, got);
    send_req(make_req(1, OP_READ, 5, 0)); // Same address on another lane untouched
    get_rsp(1'b0, got);
    send_req(make_req(0, OP_WRITE, 7, 'h3c));
    send_req(make_req(0, OP_READ, 7, 0));
    get_rsp(1'b0, got);
  endtask

  task automatic test_all_lanes;
    read_rsp_t             got;
    logic [`SPI_LANES-1:0] seen;
    seen = '0;
    for (int l = 0; l < `SPI_LANES; l++)
    begin
      send_req(make_req(l, OP_READ, l + 1, 0));
    end
    for (int l = 0; l < `SPI_LANES; l++)
    begin
      get_rsp(1'b0, got);
      check_flag("first response from this lane", seen[got.lane], 1'b0);
      seen[got.lane] = 1'b1;
    end
    check_flag("every lane answered", &seen, 1'b1);
  endtask

  task automatic test_backpressure;
    read_rsp_t got;
    int        waited;
    int        extra;
    waited = 0;
    extra  = 0;
    for (int l = 0; l < `SPI_LANES; l++)
    begin
      send_req(make_req(l, OP_READ, l, 0));
    end
    send_req(make_req(0, OP_READ, 6, 0));
    send_req(make_req(1, OP_READ, 6, 0));
    while (req_ready && (waited < WAIT_LIMIT))
    begin
      @(negedge clk);
      waited++;
    end
    if (req_ready)
    begin
      proto_errs++;
      $display("req_ready never dropped while responses were held back");
    end
    repeat (`SPI_LANES + 2)
    begin
      get_rsp(1'b0, got);
    end
    rsp_ready = 1'b1;
    repeat (200)
    begin
      @(negedge clk);
      if (rsp_valid)
      begin
        extra++;
      end
    end
    rsp_ready = 1'b0;
    checks++;
    if (extra != 0)
    begin
      proto_errs++;
      $display("Extra read responses appeared after all reads were answered");
    end
  endtask

  task automatic test_random;
    read_rsp_t got;
    bit        done;
    int        lane;
    int        addr;
    int        data;
    spi_op_e   op;
    done = 1'b0;
    fork
      begin
        for (int n = 0; n < 200; n++)
        begin
          lane = $unsigned($random(seed)) % `SPI_LANES;
          addr = $unsigned($random(seed)) % REGS;
          data = $unsigned($random(seed)) % 256;
          op   = (($random(seed) & 1) != 0) ? OP_WRITE : OP_READ;
          send_req(make_req(lane, op, addr, data));
        end
        done = 1'b1;
      end
      begin
        while (!done || (pending.size() != 0))
        begin
          if (pending.size() != 0)
          begin
            get_rsp(1'b1, got);
          end
          else
          begin
            @(negedge clk);
          end
        end
      end
    join
  endtask

  initial
  begin
    rst_n     = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    rsp_ready = 1'b0;
    for (int l = 0; l < `SPI_LANES; l++)
    begin
      for (int a = 0; a < REGS; a++)
      begin
        sb[l][a] = `SPI_DATA_W'(l * 16 + a); // Peripheral reset contents
      end
    end
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    test_reset_state();
    test_reset_values();
    test_write_read();
    test_all_lanes();
    test_backpressure();
    test_random();

    repeat (200) @(negedge clk); // Let a trailing write finish
    check_idle(cs_n, sclk);
    if (pending.size() != 0)
    begin
      proto_errs++;
      $display("%0d read responses never arrived", pending.size());
    end

    $display("Checks: %0d, value errors: %0d, protocol errors: %0d",
             checks, value_errs, proto_errs);
    if ((value_errs + proto_errs) == 0)
    begin
      $display("Simulation completed successfully");
    end
    else
    begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== testbench/spi_slave_model.sv ====
`include "spi_params.svh"

module spi_slave_model #(
  parameter int LANE = 0
) (
  input  logic clk,
  input  logic rst_n,
  input  logic sclk,
  input  logic cs_n,
  input  logic mosi,
  output logic miso
);

  localparam int HDR_BITS = 1 + `SPI_ADDR_W;

  logic [`SPI_DATA_W-1:0] regs [2**`SPI_ADDR_W];
  logic                   sclk_d;
  logic                   cs_d;
  logic [3:0]             cnt;   // Rising sclk edges seen in this frame
  logic [HDR_BITS-1:0]    hdr;   // Op bit on top, then the address
  logic [`SPI_DATA_W-1:0] wdata;

  // sclk and cs_n are oversampled on the system clock, each edge is seen one cycle late
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int a = 0; a < 2**`SPI_ADDR_W; a++)
      begin
        regs[a] <= `SPI_DATA_W'(LANE * 16 + a);
      end
      sclk_d <= 1'b0;
      cs_d   <= 1'b1;
      cnt    <= '0;
      hdr    <= '0;
      wdata  <= '0;
      miso   <= 1'b0;
    end
    else
    begin
      sclk_d <= sclk;
      cs_d   <= cs_n;
      if (cs_d && !cs_n)
      begin
        cnt <= '0; // New frame
      end
      else if (!cs_n && sclk && !sclk_d)
      begin
        if (cnt < 4'(HDR_BITS))
        begin
          hdr <= {hdr[HDR_BITS-2:0], mosi};
        end
        else
        begin
          wdata <= {wdata[`SPI_DATA_W-2:0], mosi};
        end
        cnt <= cnt + 4'd1;
      end
      else if (!cs_n && !sclk && sclk_d && !hdr[HDR_BITS-1])
      begin
        // Read data goes out MSB first once the header is complete
        if ((cnt >= 4'(HDR_BITS)) && (cnt < 4'(`SPI_CMD_W)))
        begin
          miso <= regs[hdr[`SPI_ADDR_W-1:0]][3'(4'(`SPI_CMD_W - 1) - cnt)];
        end
      end

      if (!cs_d && cs_n && hdr[HDR_BITS-1] && (cnt == 4'(`SPI_CMD_W)))
      begin
        regs[hdr[`SPI_ADDR_W-1:0]] <= wdata;
      end
    end
  end

endmodule

// ==== logic/spi_hub_top.sv ====
`include "spi_params.svh"

module spi_hub_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  req_valid,
  output logic                  req_ready,
  input  spi_pkg::host_req_t    req,
  output logic                  rsp_valid,
  input  logic                  rsp_ready,
  output spi_pkg::read_rsp_t    rsp,
  output logic [`SPI_LANES-1:0] sclk,
  output logic [`SPI_LANES-1:0] cs_n,
  output logic [`SPI_LANES-1:0] mosi,
  input  logic [`SPI_LANES-1:0] miso
);
  import spi_pkg::*;

  logic [`SPI_LANES-1:0]      cmd_valid;
  logic [`SPI_LANES-1:0]      cmd_ready;
  spi_cmd_t                   cmd;
  logic [`SPI_LANES-1:0]      rd_valid;
  logic [`SPI_LANES-1:0]      rd_ready;
  read_rsp_t [`SPI_LANES-1:0] rd;

  cmd_dispatch u_cmd_dispatch (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req       (req),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .cmd       (cmd)
  );

  // One master per peripheral, each tagging its results with its index
  for (genvar i = 0; i < `SPI_LANES; i++)
  begin : g_lane
    spi_master #(
      .LANE (i)
    ) u_spi_master (
      .clk       (clk),
      .rst_n     (rst_n),
      .cmd_valid (cmd_valid[i]),
      .cmd_ready (cmd_ready[i]),
      .cmd       (cmd),
      .rd_valid  (rd_valid[i]),
      .rd_ready  (rd_ready[i]),
      .rd        (rd[i]),
      .sclk      (sclk[i]),
      .cs_n      (cs_n[i]),
      .mosi      (mosi[i]),
      .miso      (miso[i])
    );
  end

  read_collect u_read_collect (
    .clk       (clk),
    .rst_n     (rst_n),
    .rd_valid  (rd_valid),
    .rd_ready  (rd_ready),
    .rd        (rd),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp       (rsp)
  );

endmodule

// ==== logic/read_collect.sv ====
`include "spi_params.svh"

module read_collect (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic [`SPI_LANES-1:0]                 rd_valid,
  output logic [`SPI_LANES-1:0]                 rd_ready,
  input  spi_pkg::read_rsp_t [`SPI_LANES-1:0]   rd,
  output logic                                  rsp_valid,
  input  logic                                  rsp_ready,
  output spi_pkg::read_rsp_t                    rsp
);
  import spi_pkg::*;

  logic [`SPI_LANE_W-1:0] ptr_q;
  logic [`SPI_LANE_W-1:0] gnt_idx;
  logic                   found;
  logic                   load_en;
  logic                   grant;

  assign load_en = !rsp_valid || rsp_ready; // Output register empty or draining

  // Rotating priority search starting at the pointer
  always_comb
  begin
    int idx;
    found   = 1'b0;
    gnt_idx = '0;
    for (int i = 0; i < `SPI_LANES; i++)
    begin
      idx = (int'(ptr_q) + i) % `SPI_LANES;
      if (!found && rd_valid[idx])
      begin
        found   = 1'b1;
        gnt_idx = `SPI_LANE_W'(idx);
      end
    end
  end

  assign grant = found && load_en;

  always_comb
  begin
    rd_ready = '0;
    if (grant)
    begin
      rd_ready[gnt_idx] = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rsp_valid <= 1'b0;
      ptr_q     <= '0;
    end
    else if (grant)
    begin
      rsp_valid <= 1'b1;
      ptr_q     <= (gnt_idx == `SPI_LANE_W'(`SPI_LANES - 1)) ? '0 : gnt_idx + 1'b1;
    end
    else if (rsp_ready)
    begin
      rsp_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (grant)
    begin
      rsp <= rd[gnt_idx];
    end
  end

  a_gnt_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(rd_ready));

endmodule

// ==== logic/spi_master.sv ====
`include "spi_params.svh"

module spi_master #(
  parameter int LANE = 0
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               cmd_valid,
  output logic               cmd_ready,
  input  spi_pkg::spi_cmd_t  cmd,
  output logic               rd_valid,
  input  logic               rd_ready,
  output spi_pkg::read_rsp_t rd,
  output logic               sclk,
  output logic               cs_n,
  output logic               mosi,
  input  logic               miso
);
  import spi_pkg::*;

  localparam int DIV_W    = $clog2(`SPI_CLK_DIV);
  localparam int BIT_W    = $clog2(`SPI_CMD_W + 1);
  localparam int OUT_BITS = 1 + `SPI_ADDR_W; // Read header is the op bit and the address

  lane_state_e            state_q;
  logic [DIV_W-1:0]       div_cnt;
  logic [BIT_W-1:0]       bit_cnt;
  logic [`SPI_CMD_W-1:0]  shift_q;
  logic [`SPI_DATA_W-1:0] rx_q;
  spi_op_e                op_q;
  logic [`SPI_ADDR_W-1:0] addr_q;

  logic load;
  logic tick;
  logic shifting;
  logic bits_done;
  logic rise;
  logic fall;

  // ====================
  // Strobes
  // ====================

  assign cmd_ready = (state_q == IDLE);
  assign load      = cmd_valid && cmd_ready;
  assign tick      = (div_cnt == DIV_W'(`SPI_CLK_DIV - 1)); // End of a half period
  assign shifting  = (state_q == SHIFT_OUT) || (state_q == SHIFT_IN);
  assign bits_done = (bit_cnt == BIT_W'(`SPI_CMD_W));

  // The first rising edge comes at the end of SELECT
  assign rise = tick && ((state_q == SELECT) || (shifting && !sclk && !bits_done));
  assign fall = tick && shifting && sclk;

  // ====================
  // Control
  // ====================

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q <= IDLE;
      div_cnt <= '0;
      bit_cnt <= '0;
      sclk    <= 1'b0;
      cs_n    <= 1'b1;
      mosi    <= 1'b0;
    end
    else
    begin
      if ((state_q == IDLE) || (state_q == HOLD) || tick)
      begin
        div_cnt <= '0;
      end
      else
      begin
        div_cnt <= div_cnt + 1'b1;
      end

      if (rise)
      begin
        sclk <= 1'b1;
      end
      if (fall)
      begin
        sclk    <= 1'b0;
        bit_cnt <= bit_cnt + 1'b1; // A bit is complete on its falling edge
      end

      case (state_q)
        IDLE:
        begin
          if (load)
          begin
            state_q <= SELECT;
            cs_n    <= 1'b0;
            mosi    <= cmd.op; // MSB set up before the first rising edge
            bit_cnt <= '0;
          end
        end
        SELECT:
        begin
          if (tick)
          begin
            state_q <= SHIFT_OUT;
          end
        end
        SHIFT_OUT:
        begin
          if (fall)
          begin
            if ((op_q == OP_READ) && (bit_cnt == BIT_W'(OUT_BITS - 1)))
            begin
              state_q <= SHIFT_IN; // Peripheral drives miso from here on
              mosi    <= 1'b0;
            end
            else
            begin
              mosi <= shift_q[`SPI_CMD_W-2];
            end
          end
          else if (tick && !sclk && bits_done)
          begin
            state_q <= DESELECT;
            cs_n    <= 1'b1;
            mosi    <= 1'b0;
          end
        end
        SHIFT_IN:
        begin
          if (tick && !sclk && bits_done)
          begin
            state_q <= DESELECT;
            cs_n    <= 1'b1;
          end
        end
        DESELECT:
        begin
          if (tick)
          begin
            state_q <= (op_q == OP_WRITE) ? IDLE : HOLD; // Writes finish silently
          end
        end
        HOLD:
        begin
          if (rd_ready)
          begin
            state_q <= IDLE;
          end
        end
        default:
        begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  // ====================
  // Datapath
  // ====================

  always_ff @(posedge clk)
  begin
    if (load)
    begin
      shift_q <= cmd;
      op_q    <= cmd.op;
      addr_q  <= cmd.addr;
    end
    else if (fall && (state_q == SHIFT_OUT))
    begin
      shift_q <= shift_q << 1;
    end

    if (rise && (state_q == SHIFT_IN))
    begin
      rx_q <= {rx_q[`SPI_DATA_W-2:0], miso}; // Sampled as sclk goes high
    end
  end

  assign rd_valid = (state_q == HOLD);
  assign rd       = '{lane: `SPI_LANE_W'(LANE), addr: addr_q, data: rx_q};

  a_cs_active: assert property (@(posedge clk) disable iff (!rst_n) shifting |-> !cs_n);

  // Back-pressure from the collector must not disturb a pending result
  a_rd_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rd_valid && !rd_ready |=> rd_valid && $stable(rd));

endmodule

// ==== logic/cmd_dispatch.sv ====
`include "spi_params.svh"

module cmd_dispatch (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   req_valid,
  output logic                   req_ready,
  input  spi_pkg::host_req_t     req,
  output logic [`SPI_LANES-1:0]  cmd_valid,
  input  logic [`SPI_LANES-1:0]  cmd_ready,
  output spi_pkg::spi_cmd_t      cmd
);
  import spi_pkg::*;

  host_req_t buf_q;
  logic      buf_full;
  logic      handoff;

  // Only the addressed lane sees a valid
  always_comb
  begin
    cmd_valid = '0;
    if (buf_full)
    begin
      cmd_valid[buf_q.lane] = 1'b1;
    end
  end

  assign cmd     = buf_q.cmd; // Shared bus, qualified per lane by cmd_valid
  assign handoff = |(cmd_valid & cmd_ready);

  // A busy lane keeps the buffer full and stalls the host for every lane
  assign req_ready = !buf_full || handoff;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      buf_full <= 1'b0;
    end
    else if (req_valid && req_ready)
    begin
      buf_full <= 1'b1;
    end
    else if (handoff)
    begin
      buf_full <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (req_valid && req_ready)
    begin
      buf_q <= req;
    end
  end

  a_cmd_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(cmd_valid));

endmodule

// ==== logic/spi_pkg.sv ====
`include "spi_params.svh"

package spi_pkg;

  // ====================
  // Enums
  // ====================

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } spi_op_e;

  typedef enum logic [2:0] {
    IDLE,
    SELECT,    // cs_n low, first bit set up on mosi
    SHIFT_OUT,
    SHIFT_IN,
    DESELECT,  // cs_n high for one half period
    HOLD       // Read data waits for the collector
  } lane_state_e;

  // ====================
  // Structs
  // ====================

  // Field order is the shift order, so bit 11 is the first bit on mosi
  typedef struct packed {
    spi_op_e                op;
    logic [`SPI_ADDR_W-1:0] addr;
    logic [`SPI_DATA_W-1:0] data;
  } spi_cmd_t;

  typedef struct packed {
    logic [`SPI_LANE_W-1:0] lane;
    spi_cmd_t               cmd;
  } host_req_t;

  typedef struct packed {
    logic [`SPI_LANE_W-1:0] lane;
    logic [`SPI_ADDR_W-1:0] addr;
    logic [`SPI_DATA_W-1:0] data;
  } read_rsp_t;

endpackage

// ==== logic/spi_params.svh ====
`ifndef SPI_PARAMS_SVH
`define SPI_PARAMS_SVH

// Hub geometry
`define SPI_LANES   4
`define SPI_LANE_W  2

// System clocks per sclk half period
`define SPI_CLK_DIV 4

// Command fields
`define SPI_ADDR_W  3
`define SPI_DATA_W  8
`define SPI_CMD_W   12 // Op bit, address and data shifted as one word

`endif
